//--- source/stim_pkg.sv
// Control word is fixed at 8 bits with the live flag in bit 0 and the pause length in bits 7 to 1
package stim_pkg;

   //########################################
   // Control word layout
   //########################################
   localparam int CTRL_W    = 8;                  // Bits per control word
   localparam int LIVE_BIT  = 0;                  // Set on every real entry
   localparam int PAUSE_LSB = 1;                  // Pause field starts here
   localparam int PAUSE_W   = CTRL_W - PAUSE_LSB; // 7 pause bits

   // Raw control word as stored in the table
   typedef logic [CTRL_W-1:0] ctrl_t;

   // Idle cycles inserted after a beat
   typedef logic [PAUSE_W-1:0] pause_t;

   //########################################
   // Top level defaults
   //########################################
   localparam int DEFAULT_PW    = 64;  // Payload bits
   localparam int DEFAULT_DEPTH = 256; // Table entries

   //########################################
   // Replay FSM
   //########################################
   typedef enum logic [1:0] {
      STIM_IDLE   = 2'b00, // Waiting for go
      STIM_ACTIVE = 2'b01, // Offering the current entry
      STIM_PAUSE  = 2'b10, // Counting idle cycles
      STIM_DONE   = 2'b11  // End marker reached
   } stim_state_t;

endpackage : stim_pkg

//--- source/stim_load_port.sv
// Table is written once per reset and writes beyond DEPTH entries are dropped and flagged
`timescale 1ns/1ps

module stim_load_port #(
   parameter int  DEPTH = stim_pkg::DEFAULT_DEPTH,           // Table entries
   parameter int  PW    = stim_pkg::DEFAULT_PW,              // Payload bits
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1,   // Address bits
   localparam int EW    = PW + stim_pkg::CTRL_W              // Entry bits
) (
   input  logic          ext_clk,       // Host write clock
   input  logic          nreset,        // Async reset
   input  logic          load,          // Load window from host
   input  logic          ext_valid,     // Entry strobe from host
   input  logic [EW-1:0] ext_entry,     // Payload over control word
   output logic          wr_en,         // RAM write strobe
   output logic [AW-1:0] wr_addr,       // RAM write slot
   output logic [EW-1:0] wr_entry,      // RAM write data
   output logic          load_overflow  // Sticky until reset
);

   typedef logic [AW-1:0] addr_t;

   localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

   addr_t addr_q;   // Next free slot
   logic  full_q;   // Every slot has been written
   logic  attempt;  // Host is trying to write

   //########################################
   // Write gating
   //########################################
   assign attempt  = load & ext_valid;
   assign wr_en    = attempt & ~full_q; // Dropped once full
   assign wr_addr  = addr_q;
   assign wr_entry = ext_entry;         // Stored as given

   //########################################
   // Address counter
   //########################################
   always_ff @(posedge ext_clk or negedge nreset) begin
      if (!nreset) begin
         addr_q <= '0;
         full_q <= 1'b0;
      end else if (wr_en) begin
         if (addr_q == LAST_ADDR) begin
            full_q <= 1'b1;             // Address parks on last slot
         end else begin
            addr_q <= addr_q + 1'b1;
         end
      end
   end

   // Overflow flag
   always_ff @(posedge ext_clk or negedge nreset) begin
      if (!nreset) begin
         load_overflow <= 1'b0;
      end else if (attempt & full_q) begin
         load_overflow <= 1'b1;         // Write lost past end of table
      end
   end

   //########################################
   // Checks
   //########################################
   wr_in_range: assert property (@(posedge ext_clk) disable iff (!nreset)
      wr_en |-> (wr_addr <= LAST_ADDR));

endmodule : stim_load_port

//--- source/stim_ram.sv
// Contents are undefined until loaded and the two clocks may be unrelated
`timescale 1ns/1ps

module stim_ram #(
   parameter int  DEPTH = stim_pkg::DEFAULT_DEPTH,           // Table entries
   parameter int  PW    = stim_pkg::DEFAULT_PW,              // Payload bits
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1,   // Address bits
   localparam int EW    = PW + stim_pkg::CTRL_W              // Entry bits
) (
   // Write side
   input  logic          ext_clk,   // Host clock
   input  logic          wr_en,     // Write strobe
   input  logic [AW-1:0] wr_addr,   // Write slot
   input  logic [EW-1:0] wr_entry,  // Payload over control word
   // Read side
   input  logic          dut_clk,   // DUT clock
   input  logic [AW-1:0] rd_addr,   // Next read slot
   output logic [EW-1:0] rd_entry   // Registered read data
);

   typedef logic [EW-1:0] entry_t;

   //########################################
   // Storage
   //########################################
   entry_t mem [DEPTH];  // One entry per table slot

   // Write port
   always_ff @(posedge ext_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_entry;
      end
   end

   //########################################
   // Read port
   //########################################
   // Sampled every dut_clk so rd_entry tracks the
   // address the sequencer settles on
   always_ff @(posedge dut_clk) begin
      rd_entry <= mem[rd_addr];      // One cycle latency
   end

endmodule : stim_ram

//--- source/stim_sequencer.sv
// Replays the table once per reset after go and the table must not be written during replay
`timescale 1ns/1ps

module stim_sequencer #(
   parameter int  DEPTH = stim_pkg::DEFAULT_DEPTH,           // Table entries
   parameter int  PW    = stim_pkg::DEFAULT_PW,              // Payload bits
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1,   // Address bits
   localparam int EW    = PW + stim_pkg::CTRL_W              // Entry bits
) (
   input  logic          dut_clk,      // DUT clock
   input  logic          nreset,       // Async reset
   input  logic          go,           // Start level, async
   input  logic          dut_ready,    // DUT accepts a beat
   input  logic [EW-1:0] rd_entry,     // Entry at current address
   output logic [AW-1:0] rd_addr,      // Next read address
   output logic          stim_valid,   // Packet offered
   output logic [PW-1:0] stim_packet,  // Payload of current entry
   output logic          stim_done     // Table finished
);

   import stim_pkg::*;

   typedef logic [AW-1:0] addr_t;

   localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

   logic [1:0]  go_sync_q;    // Two flop synchronizer
   logic        go_s;         // go in dut_clk domain
   stim_state_t state_q;      // FSM state
   stim_state_t state_nxt;
   addr_t       addr_q;       // Address of entry on rd_entry
   addr_t       addr_nxt;
   pause_t      pause_q;      // Idle cycles left
   pause_t      entry_pause;  // Pause field of current entry
   ctrl_t       ctrl;         // Control word of current entry
   logic        live;         // Current entry is not the end marker
   logic        beat;         // Handshake this cycle
   logic        pause_end;    // Last idle cycle

   //########################################
   // go synchronizer
   //########################################
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         go_sync_q <= 2'b00;
      end else begin
         go_sync_q <= {go_sync_q[0], go};
      end
   end

   assign go_s = go_sync_q[1];

   //########################################
   // Entry decode
   //########################################
   assign ctrl        = rd_entry[CTRL_W-1:0];
   assign live        = ctrl[LIVE_BIT];
   assign entry_pause = ctrl[CTRL_W-1:PAUSE_LSB];
   assign stim_packet = rd_entry[EW-1:CTRL_W]; // Control word stripped

   // Handshake
   // End marker is never offered, so valid also needs live
   assign stim_valid = (state_q == STIM_ACTIVE) & live;
   assign stim_done  = (state_q == STIM_DONE);
   assign beat       = stim_valid & dut_ready;
   assign pause_end  = (state_q == STIM_PAUSE) & (pause_q == pause_t'(1));

   //########################################
   // Read address
   //########################################
   // Moves only on a beat so a stalled packet holds
   always_comb begin
      addr_nxt = addr_q;
      if (beat) begin
         addr_nxt = (addr_q == LAST_ADDR) ? '0 : addr_q + 1'b1; // Wraps
      end
   end

   assign rd_addr = addr_nxt;  // RAM registers this, matching addr_q

   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         addr_q <= '0;
      end else begin
         addr_q <= addr_nxt;
      end
   end

   //########################################
   // Replay FSM
   //########################################
   always_comb begin
      state_nxt = state_q;
      case (state_q)
         STIM_IDLE: begin
            if (go_s) begin
               state_nxt = live ? STIM_ACTIVE : STIM_DONE; // Empty table
            end
         end
         STIM_ACTIVE: begin
            if (!live) begin
               state_nxt = STIM_DONE;   // End marker after a beat
            end else if (beat && (entry_pause != '0)) begin
               state_nxt = STIM_PAUSE;
            end
         end
         STIM_PAUSE: begin
            if (pause_end) begin
               state_nxt = live ? STIM_ACTIVE : STIM_DONE;
            end
         end
         STIM_DONE: begin
            state_nxt = STIM_DONE;      // Held until reset
         end
         default: begin
            state_nxt = STIM_IDLE;
         end
      endcase
   end

   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         state_q <= STIM_IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   //########################################
   // Pause counter
   //########################################
   // Loaded on the beat, so p idle cycles follow it
   always_ff @(posedge dut_clk or negedge nreset) begin
      if (!nreset) begin
         pause_q <= '0;
      end else if (beat) begin
         pause_q <= entry_pause;
      end else if (state_q == STIM_PAUSE) begin
         pause_q <= pause_q - 1'b1;     // Reaches 0 on leaving PAUSE
      end
   end

   //########################################
   // Checks
   //########################################
   // Stalled packet must not change, and the RAM read path must hold too
   packet_hold: assert property (@(posedge dut_clk) disable iff (!nreset)
      (stim_valid && !dut_ready) |=> (stim_valid && $stable(stim_packet)));

endmodule : stim_sequencer

//--- source/stim_player.sv
// Load the table with load high before go rises. A new table needs a reset.
`timescale 1ns/1ps

module stim_player #(
   parameter int PW    = stim_pkg::DEFAULT_PW,     // Payload bits
   parameter int DEPTH = stim_pkg::DEFAULT_DEPTH   // Table entries
) (
   // Control
   input  logic                          nreset,        // Async reset
   input  logic                          load,          // Load window
   input  logic                          go,            // Start replay
   // Host write side
   input  logic                          ext_clk,       // Host clock
   input  logic                          ext_valid,     // Entry strobe
   input  logic [PW+stim_pkg::CTRL_W-1:0] ext_entry,    // Payload over control
   // DUT side
   input  logic                          dut_clk,       // DUT clock
   input  logic                          dut_ready,     // DUT can accept
   output logic                          stim_valid,    // Packet offered
   output logic [PW-1:0]                 stim_packet,   // Packet to DUT
   output logic                          stim_done,     // Table finished
   output logic                          load_overflow  // Too many writes
);

   import stim_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Address bits
   localparam int EW = PW + CTRL_W;                      // Entry bits

   // ext_clk domain
   logic          wr_en;
   logic [AW-1:0] wr_addr;
   logic [EW-1:0] wr_entry;

   // dut_clk domain
   logic [AW-1:0] rd_addr;
   logic [EW-1:0] rd_entry;

   //########################################
   // Host write port
   //########################################
   stim_load_port #(
      .DEPTH (DEPTH),
      .PW    (PW)
   ) u_load_port (
      .ext_clk       (ext_clk),
      .nreset        (nreset),
      .load          (load),
      .ext_valid     (ext_valid),
      .ext_entry     (ext_entry),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_entry      (wr_entry),
      .load_overflow (load_overflow)
   );

   //########################################
   // Table memory
   //########################################
   stim_ram #(
      .DEPTH (DEPTH),
      .PW    (PW)
   ) u_ram (
      .ext_clk  (ext_clk),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_entry (wr_entry),
      .dut_clk  (dut_clk),
      .rd_addr  (rd_addr),
      .rd_entry (rd_entry)
   );

   //########################################
   // Replay
   //########################################
   stim_sequencer #(
      .DEPTH (DEPTH),
      .PW    (PW)
   ) u_sequencer (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .go          (go),
      .dut_ready   (dut_ready),
      .rd_entry    (rd_entry),
      .rd_addr     (rd_addr),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet),
      .stim_done   (stim_done)
   );

endmodule : stim_player

//--- verification/stim_tb_clock.sv
// Free running clocks from time zero and reset is held for 4 dut_clk cycles at start and on reset_req
`timescale 1ns/1ps

module stim_tb_clock (
   input  logic reset_req,  // Rising edge restarts reset
   output logic dut_clk,    // 4 ns
   output logic ext_clk,    // 6 ns
   output logic nreset      // Async, active low
);

   initial begin
      dut_clk = 1'b0;
      ext_clk = 1'b0;
   end

   always #2 dut_clk = ~dut_clk;
   always #3 ext_clk = ~ext_clk;

   // Release just after an edge, assert at once on request
   initial begin
      nreset = 1'b0;
      forever begin
         repeat (4) @(posedge dut_clk);
         #1 nreset = 1'b1;
         @(posedge reset_req);
         nreset = 1'b0;
      end
   end

endmodule : stim_tb_clock

//--- verification/stim_tb.sv
// Runs PW 64 and DEPTH 32 with a fixed LCG seed and both runs need at least one stalled beat
`timescale 1ns/1ps

module stim_tb;

   import stim_pkg::*;

   localparam int          PW    = 64;
   localparam int          DEPTH = 32;
   localparam int          EW    = PW + CTRL_W;
   localparam logic [31:0] SEED  = 32'hd083_995a;
   // 52 beats of up to 1 + 5 pause + stalls each, plus loads, resets and idle windows
   localparam int TIMEOUT_CYCLES = 4000;

   logic          dut_clk;
   logic          ext_clk;
   logic          nreset;
   logic          reset_req;
   logic          load;
   logic          go;
   logic          ext_valid;
   logic [EW-1:0] ext_entry;
   logic          dut_ready;
   logic          stim_valid;
   logic [PW-1:0] stim_packet;
   logic          stim_done;
   logic          load_overflow;

   logic [31:0]   table_state;     // LCG for table contents
   logic [31:0]   ready_state;     // LCG for back-pressure
   bit            ready_hold;      // Forces dut_ready high
   bit            second_run;      // Routes errors to the overflow test
   bit            model_overflow;
   logic [EW-1:0] wr_q[$];         // Entries to write
   logic [PW-1:0] exp_payload[$];  // Model, in replay order
   pause_t        exp_pause[$];
   int            test_errs[1:6];
   int            pass_count;
   int            fail_count;
   int            cycle_count;

   stim_tb_clock u_clock (
      .reset_req (reset_req),
      .dut_clk   (dut_clk),
      .ext_clk   (ext_clk),
      .nreset    (nreset)
   );

   stim_player #(
      .PW    (PW),
      .DEPTH (DEPTH)
   ) u_stim_player (
      .nreset        (nreset),
      .load          (load),
      .go            (go),
      .ext_clk       (ext_clk),
      .ext_valid     (ext_valid),
      .ext_entry     (ext_entry),
      .dut_clk       (dut_clk),
      .dut_ready     (dut_ready),
      .stim_valid    (stim_valid),
      .stim_packet   (stim_packet),
      .stim_done     (stim_done),
      .load_overflow (load_overflow)
   );

   //########################################
   // Helpers
   //########################################
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic int owner(input int t);
      return second_run ? 6 : t;  // Second run checks belong to test 6
   endfunction

   task automatic mismatch(input int t, input string name, input logic [63:0] exp,
                           input logic [63:0] act);
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      test_errs[t]++;
   endtask

   task automatic note_failure(input int t, input string what);
      $display("error at %0t: %s", $time, what);
      test_errs[t]++;
   endtask

   task automatic report_test(input int t, input string name);
      if (test_errs[t] == 0) begin
         $display("test %0d %s: ok", t, name);
         pass_count++;
      end else begin
         $display("test %0d %s: %0d errors", t, name, test_errs[t]);
         fail_count++;
      end
   endtask

   // Random entries with the model keeping only what fits the table
   task automatic build_table(input int n_live, input bit add_end);
      logic [PW-1:0] payload;
      pause_t        pause;
      wr_q.delete();
      exp_payload.delete();
      exp_pause.delete();
      for (int i = 0; i < n_live; i++) begin
         table_state   = lcg_next(table_state);
         payload[63:32] = table_state;
         table_state   = lcg_next(table_state);
         payload[31:0] = table_state;
         table_state   = lcg_next(table_state);
         pause         = pause_t'((table_state >> 16) % 6);  // 0 to 5
         wr_q.push_back({payload, pause, 1'b1});
         if (i < DEPTH) begin
            exp_payload.push_back(payload);
            exp_pause.push_back(pause);
         end
      end
      if (add_end) begin
         wr_q.push_back({~payload, pause_t'(0), 1'b0});  // End marker
      end
   endtask

   // One write per ext_clk and then the overflow check
   task automatic load_table();
      model_overflow = (wr_q.size() > DEPTH);
      foreach (wr_q[i]) begin
         @(posedge ext_clk);
         #1;
         load      = 1'b1;
         ext_valid = 1'b1;
         ext_entry = wr_q[i];
      end
      @(posedge ext_clk);
      #1;
      load      = 1'b0;
      ext_valid = 1'b0;
      @(posedge ext_clk);
      #1;
      if (load_overflow !== model_overflow) begin
         mismatch(owner(2), "load_overflow", model_overflow, load_overflow);
      end
   endtask

   // Nothing may come out before go
   task automatic idle_before_go(input int n);
      repeat (n) begin
         @(negedge dut_clk);
         if (stim_valid !== 1'b0) mismatch(owner(2), "stim_valid", 0, stim_valid);
         if (stim_done !== 1'b0) mismatch(owner(2), "stim_done", 0, stim_done);
      end
   endtask

   //########################################
   // Replay monitor
   //########################################
   // Samples on the falling edge, i.e. the values the next rising edge sees
   task automatic replay(input int n_beats, input bit expect_done);
      int            beats;
      int            gap;
      int            lat;
      int            stalls;
      int            exp_gap;
      bit            in_gap;
      bit            held;
      bit            seen_valid;
      bit            stop;
      pause_t        last_pause;
      logic [PW-1:0] held_pkt;
      beats      = 0;
      gap        = 0;
      lat        = 0;
      stalls     = 0;
      in_gap     = 1'b0;
      held       = 1'b0;
      seen_valid = 1'b0;
      stop       = 1'b0;
      last_pause = '0;
      @(posedge dut_clk);
      #1 go = 1'b1;  // Held for the whole run
      while (!stop && ((beats < n_beats) || (expect_done && !stim_done))) begin
         @(negedge dut_clk);
         lat++;
         ready_hold = (beats >= 6) && (beats < 14);  // Stall free window
         if (!seen_valid && stim_valid) begin
            seen_valid = 1'b1;
            if (lat > 4) note_failure(owner(2), "first stim_valid more than 4 cycles after go");
         end
         if (stim_valid && stim_done) note_failure(owner(5), "stim_valid and stim_done both high");
         if (stim_done && (beats < n_beats)) begin
            note_failure(owner(5), "stim_done rose before the last beat");
            stop = 1'b1;
         end
         // Stalled beat from last sample must still be offered unchanged
         if (held) begin
            if (!stim_valid) begin
               note_failure(owner(4), "stim_valid dropped while dut_ready was low");
            end else if (stim_packet !== held_pkt) begin
               mismatch(owner(4), "stim_packet", held_pkt, stim_packet);
            end
         end
         held     = stim_valid && !dut_ready;
         held_pkt = stim_packet;
         if (held) stalls++;
         if (in_gap) begin
            if (stim_valid) begin
               in_gap = 1'b0;
               if (gap != last_pause) mismatch(owner(3), "pause gap", last_pause, gap);
            end else if (stim_done) begin
               in_gap  = 1'b0;
               exp_gap = (last_pause == 0) ? 1 : int'(last_pause);  // Marker seen, then done
               if (gap != exp_gap) mismatch(owner(5), "stim_done delay", exp_gap, gap);
            end else begin
               gap++;
            end
         end
         if (stim_valid && dut_ready) begin
            if (beats >= n_beats) begin
               note_failure(owner(5), "beat after the end of the table");
            end else begin
               if (stim_packet !== exp_payload[beats]) begin
                  mismatch(owner(2), "stim_packet", exp_payload[beats], stim_packet);
               end
               last_pause = exp_pause[beats];
            end
            beats++;
            gap    = 0;
            in_gap = 1'b1;
         end
      end
      if (beats != n_beats) mismatch(owner(4), "beat count", n_beats, beats);
      if (stalls == 0) note_failure(owner(4), "dut_ready never stalled a beat");
   endtask

   // Done holds and nothing more is offered
   task automatic settle_after_done(input int n);
      repeat (n) begin
         @(negedge dut_clk);
         if (stim_valid !== 1'b0) mismatch(owner(5), "stim_valid", 0, stim_valid);
         if (stim_done !== 1'b1) mismatch(owner(5), "stim_done", 1, stim_done);
      end
   endtask

   task automatic restart_reset();
      @(posedge dut_clk);
      #1;
      go        = 1'b0;
      reset_req = 1'b1;
      #1 reset_req = 1'b0;
      @(posedge nreset);
      @(negedge dut_clk);
   endtask

   //########################################
   // Back-pressure and timeout
   //########################################
   always @(posedge dut_clk) begin
      #1;
      ready_state = lcg_next(ready_state);
      if (ready_hold) begin
         dut_ready = 1'b1;
      end else begin
         dut_ready = (ready_state[31:30] != 2'b00);  // Low about one cycle in four
      end
   end

   always @(posedge dut_clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run still busy after %0d dut_clk cycles", cycle_count);
         $display("TEST FAILED");
         $finish;
      end
   end

   //########################################
   // Test sequence
   //########################################
   initial begin
      load           = 1'b0;
      go             = 1'b0;
      ext_valid      = 1'b0;
      ext_entry      = '0;
      dut_ready      = 1'b0;
      reset_req      = 1'b0;
      ready_hold     = 1'b0;
      second_run     = 1'b0;
      model_overflow = 1'b0;
      table_state    = SEED;
      ready_state    = SEED;
      pass_count     = 0;
      fail_count     = 0;
      cycle_count    = 0;
      foreach (test_errs[i]) test_errs[i] = 0;
      @(posedge nreset);
      @(negedge dut_clk);
      if (stim_valid !== 1'b0) mismatch(1, "stim_valid", 0, stim_valid);
      if (stim_done !== 1'b0) mismatch(1, "stim_done", 0, stim_done);
      if (load_overflow !== 1'b0) mismatch(1, "load_overflow", 0, load_overflow);
      report_test(1, "reset state");
      // 20 live entries and an end marker
      build_table(20, 1'b1);
      load_table();
      idle_before_go(10);
      replay(20, 1'b1);
      settle_after_done(20);
      report_test(2, "order and payloads");
      report_test(3, "pause length");
      report_test(4, "back-pressure");
      report_test(5, "end of table");
      // 40 writes into 32 slots without a marker so the count stops at 32
      second_run = 1'b1;
      restart_reset();
      build_table(40, 1'b0);
      load_table();
      idle_before_go(10);
      replay(DEPTH, 1'b0);
      report_test(6, "overflow");
      $display("summary: %0d tests ok, %0d tests with errors", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule : stim_tb

//--- project.f
source/stim_pkg.sv
source/stim_load_port.sv
source/stim_ram.sv
source/stim_sequencer.sv
source/stim_player.sv
verification/stim_tb_clock.sv
verification/stim_tb.sv
